// ==== Makefile ====
# Verilator flow for the uncore testbench
SHELL     := /bin/bash
VERILATOR ?= verilator
TOP       ?= uncoreTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= SOME TESTS FAILED
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	set -o pipefail; ./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failures, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
verilog/uncorePkg.sv
verilog/addrDecoder.sv
verilog/ramAhb.sv
verilog/ahbApbBridge.sv
verilog/timerApb.sv
verilog/gpioApb.sv
verilog/uncore.sv
test/uncoreTb.sv

// ==== test/uncoreTb.sv ====
// Testbench drives a single AHB-Lite host without bursts; no transfer follows an ERROR pipelined
`timescale 1ns/1ps

module uncoreTb import uncorePkg::*; ();

  localparam real driveDelay   = 0.5;
  localparam int  readyTimeout = 20;
  localparam int  numEntries   = 18;

  typedef enum logic {
    opRead,
    opWrite
  } op_t;

  // One stimulus row with its expected response
  typedef struct packed {
    op_t                  op;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] wdata;
    logic [strbWidth-1:0] strb;
    logic [dataWidth-1:0] expData;
    logic                 expResp;
  } entry_t;

  logic                 HCLK;
  logic                 rstN;
  ahbReq_t              ahbReq;
  logic [dataWidth-1:0] HWDATA;
  logic [strbWidth-1:0] HWSTRB;
  logic [dataWidth-1:0] HRDATA;
  logic                 HREADY;
  logic                 HRESP;
  logic [dataWidth-1:0] gpioIn;
  logic [dataWidth-1:0] gpioOut;
  logic [dataWidth-1:0] gpioEn;
  logic                 mtimerInt;

  entry_t      tbl [numEntries];
  logic [31:0] rngState;
  int          checkCount;
  int          errorCount;
  int          timeoutCount;

  uncore uncore_inst (
    .HCLK, .rstN, .ahbReq, .HWDATA, .HWSTRB,
    .HRDATA, .HREADY, .HRESP,
    .gpioIn, .gpioOut, .gpioEn, .mtimerInt
  );

  // 4 ns clock period
  always #2 HCLK = ~HCLK;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic entry_t makeEntry(
    input op_t                  op,
    input logic [addrWidth-1:0] addr,
    input logic [dataWidth-1:0] wdata,
    input logic [strbWidth-1:0] strb,
    input logic [dataWidth-1:0] expData,
    input logic                 expResp
  );
    entry_t e;
    e.op      = op;
    e.addr    = addr;
    e.wdata   = wdata;
    e.strb    = strb;
    e.expData = expData;
    e.expResp = expResp;
    return e;
  endfunction

  task automatic checkValue(input string label, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("error at %0t: %s read %h expected %h", $time, label, got, exp);
    end
  endtask

  task automatic checkBit(input string label, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("error at %0t: %s is %b expected %b", $time, label, got, exp);
    end
  endtask

  // One bus cycle with an address phase plus write data of the transfer in its data phase
  task automatic busStep(
    input  logic                 addrValid,
    input  logic [addrWidth-1:0] addr,
    input  logic                 write,
    input  logic [dataWidth-1:0] wdata,
    input  logic [strbWidth-1:0] strb,
    output logic [dataWidth-1:0] rdata,
    output logic                 resp
  );
    int waited;
    ahbReq.haddr  = addr;
    ahbReq.hwrite = write;
    ahbReq.htrans = addrValid ? transNonseq : transIdle;
    ahbReq.hsize  = 3'b010;
    HWDATA        = wdata;
    HWSTRB        = strb;
    waited        = 0;
    // Ready is sampled mid cycle where it is settled
    @(negedge HCLK);
    while (!HREADY && waited < readyTimeout) begin
      waited++;
      @(negedge HCLK);
    end
    if (!HREADY) begin
      timeoutCount++;
      $display("Timeout: HREADY stayed low for %0d cycles at %0t", readyTimeout, $time);
    end
    rdata = HRDATA;
    resp  = HRESP;
    @(posedge HCLK);
    #driveDelay;
  endtask

  task automatic ahbWrite(
    input  logic [addrWidth-1:0] addr,
    input  logic [dataWidth-1:0] data,
    input  logic [strbWidth-1:0] strb,
    output logic                 resp
  );
    logic [dataWidth-1:0] unused;
    busStep(1'b1, addr, 1'b1, '0, '0, unused, resp);
    busStep(1'b0, '0, 1'b0, data, strb, unused, resp);
  endtask

  task automatic ahbRead(
    input  logic [addrWidth-1:0] addr,
    output logic [dataWidth-1:0] data,
    output logic                 resp
  );
    busStep(1'b1, addr, 1'b0, '0, '0, data, resp);
    busStep(1'b0, '0, 1'b0, '0, '0, data, resp);
  endtask

  task automatic idleCycles(input int n);
    ahbReq.htrans = transIdle;
    repeat (n) begin
      @(posedge HCLK);
      #driveDelay;
    end
  endtask

  // Waits for the timer interrupt to reach a level
  task automatic waitInterrupt(input logic level, input int maxCycles);
    int waited;
    waited = 0;
    @(negedge HCLK);
    while (mtimerInt !== level && waited < maxCycles) begin
      waited++;
      @(negedge HCLK);
    end
    if (mtimerInt !== level) begin
      timeoutCount++;
      $display("Timeout: mtimerInt did not go to %b within %0d cycles", level, maxCycles);
    end
    @(posedge HCLK);
    #driveDelay;
  endtask

  task automatic checkEntry(input int idx, input logic [31:0] rdata, input logic resp);
    checkBit($sformatf("HRESP of entry %0d", idx), resp, tbl[idx].expResp);
    if (tbl[idx].op == opRead) begin
      checkValue($sformatf("entry %0d at %h", idx, tbl[idx].addr), rdata, tbl[idx].expData);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////
  task automatic fillTable();
    // Every RAM word starts with a full write so a rerun gives the same results
    tbl[0]  = makeEntry(opWrite, 32'h8000_0010, 32'h1122_3344, 4'hF, 32'h0, 1'b0);
    tbl[1]  = makeEntry(opWrite, 32'h8000_0014, 32'h5566_7788, 4'hF, 32'h0, 1'b0);
    tbl[2]  = makeEntry(opRead,  32'h8000_0010, 32'h0, 4'h0, 32'h1122_3344, 1'b0);
    // Bytes 0 and 2 replaced
    tbl[3]  = makeEntry(opWrite, 32'h8000_0010, 32'hAABB_CCDD, 4'h5, 32'h0, 1'b0);
    tbl[4]  = makeEntry(opRead,  32'h8000_0010, 32'h0, 4'h0, 32'h11BB_33DD, 1'b0);
    // Upper half replaced
    tbl[5]  = makeEntry(opWrite, 32'h8000_0014, 32'hCAFE_0000, 4'hC, 32'h0, 1'b0);
    tbl[6]  = makeEntry(opRead,  32'h8000_0014, 32'h0, 4'h0, 32'hCAFE_7788, 1'b0);
    // Last word of the RAM
    tbl[7]  = makeEntry(opWrite, 32'h8000_0FFC, 32'h0BAD_F00D, 4'hF, 32'h0, 1'b0);
    tbl[8]  = makeEntry(opRead,  32'h8000_0FFC, 32'h0, 4'h0, 32'h0BAD_F00D, 1'b0);
    tbl[9]  = makeEntry(opRead,  32'h8000_0010, 32'h0, 4'h0, 32'h11BB_33DD, 1'b0);
    // GPIO enable and output
    tbl[10] = makeEntry(opWrite, 32'h1006_0008, 32'hFFFF_0000, 4'hF, 32'h0, 1'b0);
    tbl[11] = makeEntry(opWrite, 32'h1006_000C, 32'h1234_5678, 4'hF, 32'h0, 1'b0);
    tbl[12] = makeEntry(opWrite, 32'h1006_000C, 32'hDEAD_BEEF, 4'h3, 32'h0, 1'b0);
    tbl[13] = makeEntry(opRead,  32'h1006_0008, 32'h0, 4'h0, 32'hFFFF_0000, 1'b0);
    tbl[14] = makeEntry(opRead,  32'h1006_000C, 32'h0, 4'h0, 32'h1234_BEEF, 1'b0);
    // Unmapped window gets ERROR and the RAM still answers afterwards
    tbl[15] = makeEntry(opRead,  32'h4000_0000, 32'h0, 4'h0, 32'h0, 1'b1);
    tbl[16] = makeEntry(opWrite, 32'h4000_0000, 32'h0000_0001, 4'hF, 32'h0, 1'b1);
    tbl[17] = makeEntry(opRead,  32'h8000_0FFC, 32'h0, 4'h0, 32'h0BAD_F00D, 1'b0);
  endtask

  // Pipelined runs overlap each address phase with the previous data phase
  task automatic runTable(input int first, input int last, input logic pipelined);
    logic [dataWidth-1:0] rdata;
    logic                 resp;
    for (int i = first; i <= last; i++) begin
      if (pipelined && i > first) begin
        busStep(1'b1, tbl[i].addr, tbl[i].op == opWrite,
                tbl[i-1].wdata, tbl[i-1].strb, rdata, resp);
        checkEntry(i - 1, rdata, resp);
      end else begin
        busStep(1'b1, tbl[i].addr, tbl[i].op == opWrite, '0, '0, rdata, resp);
      end
      if (!pipelined) begin
        busStep(1'b0, '0, 1'b0, tbl[i].wdata, tbl[i].strb, rdata, resp);
        checkEntry(i, rdata, resp);
      end
    end
    if (pipelined) begin
      busStep(1'b0, '0, 1'b0, tbl[last].wdata, tbl[last].strb, rdata, resp);
      checkEntry(last, rdata, resp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [dataWidth-1:0] rdata;
    logic                 resp;
    logic [dataWidth-1:0] timeA;
    logic [dataWidth-1:0] timeB;
    logic [dataWidth-1:0] timeHi;
    HCLK         = 1'b0;
    rstN         = 1'b0;
    ahbReq       = '0;
    HWDATA       = '0;
    HWSTRB       = '0;
    gpioIn       = '0;
    rngState     = 32'hd9ff;
    checkCount   = 0;
    errorCount   = 0;
    timeoutCount = 0;
    fillTable();
    repeat (10) @(posedge HCLK);
    #driveDelay;
    rstN = 1'b1;

    // Idle bus and quiet peripherals out of reset
    @(negedge HCLK);
    checkBit("HREADY after reset", HREADY, 1'b1);
    checkBit("HRESP after reset", HRESP, 1'b0);
    checkBit("mtimerInt after reset", mtimerInt, 1'b0);
    checkValue("gpioOut after reset", gpioOut, 32'h0);
    checkValue("gpioEn after reset", gpioEn, 32'h0);
    @(posedge HCLK);
    #driveDelay;

    // Whole table with idle gaps and then RAM and GPIO rows back to back
    runTable(0, numEntries - 1, 1'b0);
    checkValue("gpioEn port", gpioEn, 32'hFFFF_0000);
    checkValue("gpioOut port", gpioOut, 32'h1234_BEEF);
    runTable(0, 14, 1'b1);

    // GPIO input through the synchronizer
    rngState = xorshift(rngState);
    gpioIn   = rngState;
    idleCycles(4);
    ahbRead(32'h1006_0000, rdata, resp);
    checkValue("gpioIn register", rdata, rngState);

    // mtime keeps counting
    ahbRead(32'h0200_BFF8, timeA, resp);
    idleCycles(8);
    ahbRead(32'h0200_BFF8, timeB, resp);
    checkCount++;
    if (!(timeB > timeA)) begin
      errorCount++;
      $display("error at %0t: mtimeLo went from %h to %h, expected growth", $time, timeA, timeB);
    end

    // Compare 50 ticks ahead with the high half first so nothing matches early
    ahbRead(32'h0200_BFF8, timeA, resp);
    ahbRead(32'h0200_BFFC, timeHi, resp);
    ahbWrite(32'h0200_4004, timeHi, 4'hF, resp);
    ahbWrite(32'h0200_4000, timeA + 32'd50, 4'hF, resp);
    checkBit("mtimerInt before match", mtimerInt, 1'b0);
    waitInterrupt(1'b1, 200);
    ahbWrite(32'h0200_4000, 32'hFFFF_FFFF, 4'hF, resp);
    ahbWrite(32'h0200_4004, 32'hFFFF_FFFF, 4'hF, resp);
    waitInterrupt(1'b0, 5);

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/addrDecoder.sv ====
// Selects are combinational from haddr and htrans; unmapped transfers get the two-cycle ERROR
`timescale 1ns/1ps

module addrDecoder import uncorePkg::*; (
  input  logic    HCLK,
  input  logic    rstN,
  input  ahbReq_t ahbReq,
  input  logic    HREADY,
  output logic    hselRam,
  output logic    hselTimer,
  output logic    hselGpio,
  output region_t dataRegion,
  output logic    noneReady,
  output logic    noneResp
);

  logic    transValid;
  logic    hselNone;
  region_t addrRegion;
  logic    errData;
  logic    errSecond;

  // Only NONSEQ and SEQ carry a transfer
  assign transValid = (ahbReq.htrans == transNonseq) || (ahbReq.htrans == transSeq);

  //////////////////////////////////////////////////////////////
  // Address phase decode
  //////////////////////////////////////////////////////////////
  assign hselRam   = transValid && ((ahbReq.haddr & ~ramRange) == ramBase);
  assign hselTimer = transValid && ((ahbReq.haddr & ~timerRange) == timerBase);
  assign hselGpio  = transValid && ((ahbReq.haddr & ~gpioRange) == gpioBase);
  // Valid transfer that hits no window
  assign hselNone  = transValid && !(hselRam || hselTimer || hselGpio);

  always_comb begin
    addrRegion = regionNone;
    if (hselRam) begin
      addrRegion = regionRam;
    end else if (hselTimer) begin
      addrRegion = regionTimer;
    end else if (hselGpio) begin
      addrRegion = regionGpio;
    end
  end

  // Data phase region held while a subordinate stalls
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      dataRegion <= regionNone;
      errData    <= 1'b0;
    end else if (HREADY) begin
      dataRegion <= addrRegion;
      errData    <= hselNone;
    end
  end

  // Default subordinate ERROR with low ready first and high ready second
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      errSecond <= 1'b0;
    end else begin
      errSecond <= errData && !errSecond;
    end
  end

  assign noneReady = !errData || errSecond;
  assign noneResp  = errData;

  // Windows must never overlap
  assert property (@(posedge HCLK) disable iff (!rstN)
    $onehot0({hselRam, hselTimer, hselGpio}));

endmodule

// ==== verilog/ahbApbBridge.sv ====
// Fixed three-cycle AHB to APB bridge for timer and GPIO; no PREADY or PSLVERR, never errors
`timescale 1ns/1ps

module ahbApbBridge import uncorePkg::*; (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  ahbReq_t              ahbReq,
  input  logic                 hselTimer,
  input  logic                 hselGpio,
  input  logic                 HREADY,
  input  logic [dataWidth-1:0] HWDATA,
  input  logic [strbWidth-1:0] HWSTRB,
  input  logic [dataWidth-1:0] timerRdata,
  input  logic [dataWidth-1:0] gpioRdata,
  output apbReq_t              apbReq,
  output logic                 pselTimer,
  output logic                 pselGpio,
  output logic [dataWidth-1:0] bridgeRdata,
  output logic                 bridgeReady
);

  typedef enum logic [1:0] {
    stIdle,
    stCapture,
    stSetup,
    stAccess
  } bridgeState_t;

  bridgeState_t         state;
  bridgeState_t         stateNext;
  logic                 accept;
  logic                 selTimerQ;
  logic                 selGpioQ;
  logic [15:0]          paddrQ;
  logic                 pwriteQ;
  logic [dataWidth-1:0] pwdataQ;
  logic [strbWidth-1:0] pstrbQ;

  // New APB-bound transfer accepted this edge
  assign accept = HREADY && (hselTimer || hselGpio);

  //////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////
  always_comb begin
    case (state)
      stIdle:    stateNext = accept ? stCapture : stIdle;
      stCapture: stateNext = stSetup;
      stSetup:   stateNext = stAccess;
      // Access ends the data phase and a pipelined transfer may follow
      default:   stateNext = accept ? stCapture : stIdle;
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      state     <= stIdle;
      selTimerQ <= 1'b0;
      selGpioQ  <= 1'b0;
    end else begin
      state <= stateNext;
      if (accept) begin
        selTimerQ <= hselTimer;
        selGpioQ  <= hselGpio;
      end
    end
  end

  // Address leaves the bus at acceptance and write data arrives in capture
  always_ff @(posedge HCLK) begin
    if (accept) begin
      paddrQ  <= ahbReq.haddr[15:0];
      pwriteQ <= ahbReq.hwrite;
    end
    if (state == stCapture) begin
      pwdataQ <= HWDATA;
      pstrbQ  <= HWSTRB & {strbWidth{pwriteQ}};
    end
  end

  //////////////////////////////////////////////////////////////
  // APB outputs
  //////////////////////////////////////////////////////////////
  always_comb begin
    apbReq.paddr   = paddrQ;
    apbReq.pwdata  = pwdataQ;
    apbReq.pstrb   = pstrbQ;
    apbReq.pwrite  = pwriteQ;
    apbReq.penable = (state == stAccess);
  end

  assign pselTimer = selTimerQ && ((state == stSetup) || (state == stAccess));
  assign pselGpio  = selGpioQ && ((state == stSetup) || (state == stAccess));

  // Read data passes straight through in access
  assign bridgeReady = (state == stAccess);
  assign bridgeRdata = (state != stAccess) ? '0 : (selTimerQ ? timerRdata : gpioRdata);

  // PENABLE only right after a setup cycle to the same peripheral
  assert property (@(posedge HCLK) disable iff (!rstN)
    apbReq.penable |-> ($past(pselTimer || pselGpio) && !$past(apbReq.penable) &&
                        $stable({pselTimer, pselGpio})));

endmodule

// ==== verilog/gpioApb.sv ====
// 32-bit GPIO without interrupts or IOF; gpioIn reads two cycles late through a synchronizer
`timescale 1ns/1ps

module gpioApb import uncorePkg::*; (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  apbReq_t              apbReq,
  input  logic                 psel,
  output logic [dataWidth-1:0] prdata,
  input  logic [dataWidth-1:0] gpioIn,
  output logic [dataWidth-1:0] gpioOut,
  output logic [dataWidth-1:0] gpioEn
);

  logic [dataWidth-1:0] inMeta;
  logic [dataWidth-1:0] inSync;
  logic                 wrEn;

  assign wrEn = psel && apbReq.penable && apbReq.pwrite;

  // Pins are asynchronous to HCLK
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      inMeta <= '0;
      inSync <= '0;
    end else begin
      inMeta <= gpioIn;
      inSync <= inMeta;
    end
  end

  // Output and enable registers
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      gpioOut <= '0;
      gpioEn  <= '0;
    end else if (wrEn) begin
      if (apbReq.paddr == gpioOutOff) begin
        gpioOut <= mergeBytes(gpioOut, apbReq.pwdata, apbReq.pstrb);
      end
      if (apbReq.paddr == gpioEnOff) begin
        gpioEn <= mergeBytes(gpioEn, apbReq.pwdata, apbReq.pstrb);
      end
    end
  end

  always_comb begin
    case (apbReq.paddr)
      gpioInOff:  prdata = inSync;
      gpioEnOff:  prdata = gpioEn;
      gpioOutOff: prdata = gpioOut;
      default:    prdata = '0;
    endcase
  end

endmodule

// ==== verilog/ramAhb.sv ====
// 4 KiB RAM with zero wait states; word addressed, hsize ignored, HWSTRB picks the bytes
`timescale 1ns/1ps

module ramAhb import uncorePkg::*; (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  ahbReq_t              ahbReq,
  input  logic                 hsel,
  input  logic                 HREADY,
  input  logic [dataWidth-1:0] HWDATA,
  input  logic [strbWidth-1:0] HWSTRB,
  output logic [dataWidth-1:0] ramRdata
);

  logic [dataWidth-1:0]    mem [ramWords];
  logic [ramAddrWidth-1:0] addrQ;
  logic                    wrValid;

  //////////////////////////////////////////////////////////////
  // Address phase capture
  //////////////////////////////////////////////////////////////

  // Data phase write flag
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      wrValid <= 1'b0;
    end else if (HREADY) begin
      wrValid <= hsel && ahbReq.hwrite;
    end
  end

  // Word address of the accepted transfer
  always_ff @(posedge HCLK) begin
    if (hsel && HREADY) begin
      addrQ <= ahbReq.haddr[ramAddrWidth+1:2];
    end
  end

  //////////////////////////////////////////////////////////////
  // Data phase
  //////////////////////////////////////////////////////////////

  // Strobed byte write as the data phase ends
  always_ff @(posedge HCLK) begin
    if (wrValid && HREADY) begin
      for (int i = 0; i < strbWidth; i++) begin
        if (HWSTRB[i]) begin
          mem[addrQ][8*i +: 8] <= HWDATA[8*i +: 8];
        end
      end
    end
  end

  // Read is asynchronous on the registered address
  // so a write then read of one word sees the merged word
  assign ramRdata = mem[addrQ];

endmodule

// ==== verilog/timerApb.sv ====
// Machine timer counting HCLK cycles; mtimecmp resets to all ones so the interrupt starts low
`timescale 1ns/1ps

module timerApb import uncorePkg::*; (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  apbReq_t              apbReq,
  input  logic                 psel,
  output logic [dataWidth-1:0] prdata,
  output logic                 mtimerInt
);

  logic [63:0] mtime;
  logic [63:0] mtimeNext;
  logic [63:0] mtimecmp;
  logic        wrEn;

  // Write commits in the APB access cycle
  assign wrEn = psel && apbReq.penable && apbReq.pwrite;

  //////////////////////////////////////////////////////////////
  // mtime counter
  //////////////////////////////////////////////////////////////
  always_comb begin
    mtimeNext = mtime + 64'd1;
    // A write replaces that half instead of counting
    if (wrEn && (apbReq.paddr == mtimeLo)) begin
      mtimeNext[31:0] = mergeBytes(mtime[31:0], apbReq.pwdata, apbReq.pstrb);
    end
    if (wrEn && (apbReq.paddr == mtimeHi)) begin
      mtimeNext[63:32] = mergeBytes(mtime[63:32], apbReq.pwdata, apbReq.pstrb);
    end
  end

  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      mtime     <= '0;
      mtimecmp  <= '1;
      mtimerInt <= 1'b0;
    end else begin
      mtime     <= mtimeNext;
      mtimerInt <= (mtime >= mtimecmp);
      // Compare register in 32-bit halves
      if (wrEn && (apbReq.paddr == mtimecmpLo)) begin
        mtimecmp[31:0] <= mergeBytes(mtimecmp[31:0], apbReq.pwdata, apbReq.pstrb);
      end
      if (wrEn && (apbReq.paddr == mtimecmpHi)) begin
        mtimecmp[63:32] <= mergeBytes(mtimecmp[63:32], apbReq.pwdata, apbReq.pstrb);
      end
    end
  end

  // Read mux where unknown offsets read zero
  always_comb begin
    case (apbReq.paddr)
      mtimecmpLo: prdata = mtimecmp[31:0];
      mtimecmpHi: prdata = mtimecmp[63:32];
      mtimeLo:    prdata = mtime[31:0];
      mtimeHi:    prdata = mtime[63:32];
      default:    prdata = '0;
    endcase
  end

endmodule

// ==== verilog/uncore.sv ====
// Uncore top; host must hold ahbReq steady while HREADY is low, latency depends on region
`timescale 1ns/1ps

module uncore import uncorePkg::*; (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  ahbReq_t              ahbReq,
  input  logic [dataWidth-1:0] HWDATA,
  input  logic [strbWidth-1:0] HWSTRB,
  output logic [dataWidth-1:0] HRDATA,
  output logic                 HREADY,
  output logic                 HRESP,
  input  logic [dataWidth-1:0] gpioIn,
  output logic [dataWidth-1:0] gpioOut,
  output logic [dataWidth-1:0] gpioEn,
  output logic                 mtimerInt
);

  logic                 hselRam;
  logic                 hselTimer;
  logic                 hselGpio;
  region_t              dataRegion;
  logic                 noneReady;
  logic                 noneResp;
  logic [dataWidth-1:0] ramRdata;
  apbReq_t              apbReq;
  logic                 pselTimer;
  logic                 pselGpio;
  logic [dataWidth-1:0] timerRdata;
  logic [dataWidth-1:0] gpioRdata;
  logic [dataWidth-1:0] bridgeRdata;
  logic                 bridgeReady;

  //////////////////////////////////////////////////////////////
  // AHB side
  //////////////////////////////////////////////////////////////
  addrDecoder addrDecoder_inst (
    .HCLK, .rstN, .ahbReq, .HREADY,
    .hselRam, .hselTimer, .hselGpio,
    .dataRegion, .noneReady, .noneResp
  );

  ramAhb ramAhb_inst (
    .HCLK, .rstN, .ahbReq, .hsel(hselRam), .HREADY,
    .HWDATA, .HWSTRB, .ramRdata
  );

  ahbApbBridge ahbApbBridge_inst (
    .HCLK, .rstN, .ahbReq, .hselTimer, .hselGpio, .HREADY,
    .HWDATA, .HWSTRB, .timerRdata, .gpioRdata,
    .apbReq, .pselTimer, .pselGpio, .bridgeRdata, .bridgeReady
  );

  // APB peripherals
  timerApb timerApb_inst (
    .HCLK, .rstN, .apbReq, .psel(pselTimer), .prdata(timerRdata), .mtimerInt
  );

  gpioApb gpioApb_inst (
    .HCLK, .rstN, .apbReq, .psel(pselGpio), .prdata(gpioRdata),
    .gpioIn, .gpioOut, .gpioEn
  );

  // Response mux on the data phase region
  always_comb begin
    case (dataRegion)
      regionRam: begin
        HRDATA = ramRdata;
        HREADY = 1'b1;
        HRESP  = 1'b0;
      end
      regionTimer, regionGpio: begin
        HRDATA = bridgeRdata;
        HREADY = bridgeReady;
        HRESP  = 1'b0;
      end
      // Idle or unmapped transfers get the default subordinate
      default: begin
        HRDATA = '0;
        HREADY = noneReady;
        HRESP  = noneResp;
      end
    endcase
  end

endmodule

// ==== verilog/uncorePkg.sv ====
// Memory map and bus types for a 32-bit AHB-Lite uncore without bursts, HPROT or lock
package uncorePkg;

  // Bus widths
  localparam int dataWidth = 32;
  localparam int addrWidth = 32;
  localparam int strbWidth = dataWidth / 8;

  //////////////////////////////////////////////////////////////
  // Memory map where a window hits when (haddr & ~range) == base
  //////////////////////////////////////////////////////////////
  localparam logic [addrWidth-1:0] ramBase    = 32'h8000_0000;
  localparam logic [addrWidth-1:0] ramRange   = 32'h0000_0FFF;
  localparam logic [addrWidth-1:0] timerBase  = 32'h0200_0000;
  localparam logic [addrWidth-1:0] timerRange = 32'h0000_FFFF;
  localparam logic [addrWidth-1:0] gpioBase   = 32'h1006_0000;
  localparam logic [addrWidth-1:0] gpioRange  = 32'h0000_00FF;

  // On-chip RAM depth in words
  localparam int ramWords     = 1024;
  localparam int ramAddrWidth = $clog2(ramWords);

  // HTRANS encodings
  localparam logic [1:0] transIdle   = 2'b00;
  localparam logic [1:0] transNonseq = 2'b10;
  localparam logic [1:0] transSeq    = 2'b11;

  // Timer register offsets
  localparam logic [15:0] mtimecmpLo = 16'h4000;
  localparam logic [15:0] mtimecmpHi = 16'h4004;
  localparam logic [15:0] mtimeLo    = 16'hBFF8;
  localparam logic [15:0] mtimeHi    = 16'hBFFC;

  // GPIO register offsets
  localparam logic [15:0] gpioInOff  = 16'h0000;
  localparam logic [15:0] gpioEnOff  = 16'h0008;
  localparam logic [15:0] gpioOutOff = 16'h000C;

  typedef enum logic [1:0] {
    regionNone,
    regionRam,
    regionTimer,
    regionGpio
  } region_t;

  // AHB address phase
  typedef struct packed {
    logic [addrWidth-1:0] haddr;
    logic                 hwrite;
    logic [1:0]           htrans;
    logic [2:0]           hsize;
  } ahbReq_t;

  // APB request from the bridge
  typedef struct packed {
    logic [15:0]          paddr;
    logic [dataWidth-1:0] pwdata;
    logic [strbWidth-1:0] pstrb;
    logic                 pwrite;
    logic                 penable;
  } apbReq_t;

  // Strobed bytes of newWord replace those of oldWord
  function automatic logic [dataWidth-1:0] mergeBytes(
    input logic [dataWidth-1:0] oldWord,
    input logic [dataWidth-1:0] newWord,
    input logic [strbWidth-1:0] strb
  );
    logic [dataWidth-1:0] result;
    result = oldWord;
    for (int i = 0; i < strbWidth; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = newWord[8*i +: 8];
      end
    end
    return result;
  endfunction

endpackage
